// File: verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// opcodes
	localparam logic [6:0] OP_R       = 7'b0000011;
	localparam logic [6:0] OP_R_I     = 7'b1000011;
	localparam logic [6:0] OP_U_LUI   = 7'b0100011;
	localparam logic [6:0] OP_U_AUIPC = 7'b0110011;
	localparam logic [6:0] OP_SB      = 7'b0010011;
	localparam logic [6:0] OP_UJ      = 7'b0001011;
	localparam logic [6:0] OP_S       = 7'b0001111;
	localparam logic [6:0] OP_I       = 7'b0000111;

	localparam logic [3:0] ALU_ADD    = 4'b0000;
	localparam logic [3:0] ALU_SLT    = 4'b0001;
	localparam logic [3:0] ALU_SLTU   = 4'b0010;
	localparam logic [3:0] ALU_AND    = 4'b0011;
	localparam logic [3:0] ALU_OR     = 4'b0100;
	localparam logic [3:0] ALU_XOR    = 4'b0101;
	localparam logic [3:0] ALU_SLL    = 4'b0110;
	localparam logic [3:0] ALU_SRL    = 4'b0111;
	localparam logic [3:0] ALU_SUB    = 4'b1000;
	localparam logic [3:0] ALU_SRA    = 4'b1001;
	localparam logic [3:0] ALU_PASS_B = 4'b1010;

	localparam logic [1:0] BR_EQ = 2'b00;
	localparam logic [1:0] BR_NE = 2'b01;
	localparam logic [1:0] BR_LT = 2'b10;
	localparam logic [1:0] BR_GE = 2'b11;

	// store byte enables, low part of load extension
	localparam logic [1:0] W_FULL = 2'b00;
	localparam logic [1:0] W_HALF = 2'b01;
	localparam logic [1:0] W_BYTE = 2'b10;

	typedef union packed {
		struct packed {
			logic [6:0] hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] fnct;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  fnct;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
	} instr_t;

	typedef enum logic [2:0] {
		S_IDLE,
		S_FETCH,
		S_EXEC,
		S_MEM,
		S_WB,
		S_HALT
	} seq_state_t;

endpackage

`default_nettype wire

// File: verilog/cpu_cntr.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_cntr
	import cpu_pkg::*;
(
	input  instr_t     instr,
	output logic       sel_a_pc,
	output logic       sel_b_imm,
	output logic       sel_wb_mem,
	output logic       sel_wb_link,
	output logic       is_branch,
	output logic       is_jump,
	output logic       we_mem,
	output logic       we_reg,
	output logic [1:0] be_mem,
	output logic [1:0] brn_type,
	output logic [2:0] sx_cntl,
	output logic [3:0] alu_cntr,
	output logic       alu_s_u,
	output logic       illegal
);

	logic [1:0] fnct7;
	logic [2:0] fnct;

	assign fnct7 = instr.r.hi[6:5];
	assign fnct = instr.r.fnct;

	always_comb begin
		sel_a_pc = 1'b0;
		sel_b_imm = 1'b0;
		sel_wb_mem = 1'b0;
		sel_wb_link = 1'b0;
		is_branch = 1'b0;
		is_jump = 1'b0;
		we_mem = 1'b0;
		we_reg = 1'b0;
		be_mem = W_FULL;
		brn_type = BR_EQ;
		sx_cntl = {1'b1, W_FULL};
		alu_cntr = ALU_ADD;
		alu_s_u = 1'b1;
		illegal = 1'b0;
		case (instr.r.opcode)
			OP_R: begin
				we_reg = 1'b1;
				if (fnct7 == 2'b00) begin
					case (fnct)
						3'b000: alu_cntr = ALU_ADD;
						3'b001: alu_cntr = ALU_SLT;
						3'b010: alu_cntr = ALU_SLTU;
						3'b011: alu_cntr = ALU_AND;
						3'b100: alu_cntr = ALU_OR;
						3'b101: alu_cntr = ALU_XOR;
						3'b110: alu_cntr = ALU_SLL;
						default: alu_cntr = ALU_SRL;
					endcase
				end else begin
					case (fnct)
						3'b000: alu_cntr = ALU_SUB;
						3'b001: alu_cntr = ALU_SRA;
						3'b010: alu_cntr = ALU_PASS_B;
						default: illegal = 1'b1;
					endcase
				end
			end
			OP_R_I: begin
				we_reg = 1'b1;
				sel_b_imm = 1'b1;
				case (fnct)
					3'b000: alu_cntr = ALU_ADD;
					3'b001: alu_cntr = ALU_SLT;
					3'b010: alu_cntr = ALU_AND;
					3'b011: alu_cntr = ALU_OR;
					3'b100: alu_cntr = ALU_XOR;
					3'b101: alu_cntr = ALU_SLL;
					3'b110: alu_cntr = ALU_SRL;
					default: alu_cntr = ALU_SRA;
				endcase
			end
			OP_U_LUI: begin
				we_reg = 1'b1;
				sel_b_imm = 1'b1;
				alu_cntr = ALU_PASS_B;
			end
			OP_U_AUIPC: begin
				we_reg = 1'b1;
				sel_a_pc = 1'b1;
				sel_b_imm = 1'b1;
			end
			OP_SB: begin
				is_branch = 1'b1;
				alu_cntr = ALU_SUB;
				case (fnct)
					3'b000: brn_type = BR_EQ;
					3'b001: brn_type = BR_NE;
					3'b010: brn_type = BR_LT;
					3'b011: begin
						brn_type = BR_LT;
						alu_s_u = 1'b0;
					end
					3'b100: brn_type = BR_GE;
					3'b101: begin
						brn_type = BR_GE;
						alu_s_u = 1'b0;
					end
					default: illegal = 1'b1;
				endcase
			end
			OP_UJ: begin
				// target from pc + offset, link goes to rd
				is_jump = 1'b1;
				we_reg = 1'b1;
				sel_a_pc = 1'b1;
				sel_b_imm = 1'b1;
				sel_wb_link = 1'b1;
			end
			OP_I: begin
				we_reg = 1'b1;
				sel_b_imm = 1'b1;
				case (fnct)
					3'b000: begin
						is_jump = 1'b1;
						sel_wb_link = 1'b1;
					end
					3'b001: sel_wb_mem = 1'b1;
					3'b010: begin
						sel_wb_mem = 1'b1;
						be_mem = W_HALF;
						sx_cntl = {1'b1, W_HALF};
					end
					3'b011: begin
						sel_wb_mem = 1'b1;
						be_mem = W_HALF;
						sx_cntl = {1'b0, W_HALF};
					end
					3'b100: begin
						sel_wb_mem = 1'b1;
						be_mem = W_BYTE;
						sx_cntl = {1'b1, W_BYTE};
					end
					3'b101: begin
						sel_wb_mem = 1'b1;
						be_mem = W_BYTE;
						sx_cntl = {1'b0, W_BYTE};
					end
					default: illegal = 1'b1;
				endcase
			end
			OP_S: begin
				we_mem = 1'b1;
				sel_b_imm = 1'b1;
				case (fnct)
					3'b001: be_mem = W_FULL;
					3'b010: be_mem = W_HALF;
					3'b011: be_mem = W_BYTE;
					default: illegal = 1'b1;
				endcase
			end
			default: illegal = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/cpu_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_sequencer
	import cpu_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       run,
	input  logic       is_mem,
	input  logic       illegal,
	input  logic       take,
	output seq_state_t state,
	output logic       ir_load,
	output logic       result_load,
	output logic       mem_we,
	output logic       reg_we_phase,
	output logic       pc_step,
	output logic       pc_jump,
	output logic       retire,
	output logic       halted
);

	seq_state_t next_state;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= S_IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			S_IDLE: begin
				if (run)
					next_state = S_FETCH;
			end
			S_FETCH: next_state = S_EXEC;
			S_EXEC: begin
				// bad opcode stops the core before any write
				if (illegal)
					next_state = S_HALT;
				else if (is_mem)
					next_state = S_MEM;
				else
					next_state = S_WB;
			end
			S_MEM: next_state = S_WB;
			S_WB: next_state = S_FETCH;
			S_HALT: next_state = S_HALT;
			default: next_state = S_IDLE;
		endcase
	end

	assign ir_load = (state == S_FETCH);
	assign result_load = (state == S_EXEC) && !illegal;
	assign mem_we = (state == S_MEM);
	assign reg_we_phase = (state == S_WB);
	assign pc_step = (state == S_WB) && !take;
	assign pc_jump = (state == S_WB) && take;
	assign retire = (state == S_WB);
	assign halted = (state == S_HALT);

endmodule

`default_nettype wire

// File: verilog/pc_counter.sv
`timescale 1ns/10ps
`default_nettype none

module pc_counter #(
	parameter int CODE_DEPTH = 64
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        step,
	input  logic        jump,
	input  logic [31:0] target,
	output logic [31:0] pc,
	output logic [31:0] pc_plus4
);

	// one past the last code byte
	localparam logic [31:0] PC_LIMIT = 32'(CODE_DEPTH * 4);

	assign pc_plus4 = pc + 32'd4;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (jump) begin
			pc <= {target[31:2], 2'b00};
		end else if (step) begin
			if (pc_plus4 >= PC_LIMIT)
				pc <= '0;
			else
				pc <= pc_plus4;
		end
	end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        we,
	input  logic [4:0]  waddr,
	input  logic [4:0]  raddr_a,
	input  logic [4:0]  raddr_b,
	input  logic [31:0] wdata,
	output logic [31:0] rdata_a,
	output logic [31:0] rdata_b
);

	logic [31:0] regs [32];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int n = 0; n < 32; n++)
				regs[n] <= '0;
		end else if (we && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	// x0 is hardwired
	assign rdata_a = (raddr_a == 5'd0) ? 32'd0 : regs[raddr_a];
	assign rdata_b = (raddr_b == 5'd0) ? 32'd0 : regs[raddr_b];

endmodule

`default_nettype wire

// File: verilog/cpu_alu.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_alu
	import cpu_pkg::*;
(
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  logic [3:0]  alu_cntr,
	input  logic        alu_s_u,
	input  logic [1:0]  brn_type,
	output logic [31:0] result,
	output logic        taken
);

	logic [4:0] shamt;
	logic       eq;
	logic       lt_s;
	logic       lt_u;
	logic       lt;

	assign shamt = b[4:0];
	assign eq = (a == b);
	assign lt_s = ($signed(a) < $signed(b));
	assign lt_u = (a < b);
	assign lt = alu_s_u ? lt_s : lt_u;

	always_comb begin
		case (alu_cntr)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_SLT: result = {31'd0, lt_s};
			ALU_SLTU: result = {31'd0, lt_u};
			ALU_AND: result = a & b;
			ALU_OR: result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_SLL: result = a << shamt;
			ALU_SRL: result = a >> shamt;
			ALU_SRA: result = $signed(a) >>> shamt;
			ALU_PASS_B: result = b;
			default: result = '0;
		endcase
	end

	// branch decision, only looked at for SB
	always_comb begin
		case (brn_type)
			BR_EQ: taken = eq;
			BR_NE: taken = !eq;
			BR_LT: taken = lt;
			default: taken = !lt;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/data_mem.sv
`timescale 1ns/10ps
`default_nettype none

module data_mem
	import cpu_pkg::*;
#(
	parameter int DATA_DEPTH = 64
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        we,
	input  logic [31:0] addr,
	input  logic [31:0] wdata,
	input  logic [1:0]  be_mem,
	input  logic [2:0]  sx_cntl,
	output logic [31:0] rdata
);

	localparam int DA_W = $clog2(DATA_DEPTH);

	logic [3:0][7:0] mem [DATA_DEPTH];
	logic [DA_W-1:0] word_idx;
	logic [3:0]      lane_en;
	logic [31:0]     wr_word;
	logic [31:0]     rd_word;
	logic [15:0]     rd_half;
	logic [7:0]      rd_byte;

	assign word_idx = addr[DA_W+1:2];

	// lanes and replicated data per store width
	always_comb begin
		case (be_mem)
			W_HALF: begin
				lane_en = addr[1] ? 4'b1100 : 4'b0011;
				wr_word = {2{wdata[15:0]}};
			end
			W_BYTE: begin
				lane_en = 4'b0001 << addr[1:0];
				wr_word = {4{wdata[7:0]}};
			end
			default: begin
				lane_en = 4'b1111;
				wr_word = wdata;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		for (int l = 0; l < 4; l++) begin
			if (we && lane_en[l])
				mem[word_idx][l] <= wr_word[8*l +: 8];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rd_word <= '0;
		else
			rd_word <= mem[word_idx];
	end

	assign rd_half = addr[1] ? rd_word[31:16] : rd_word[15:0];
	assign rd_byte = rd_word[8*addr[1:0] +: 8];

	always_comb begin
		case (sx_cntl[1:0])
			W_HALF: rdata = {{16{sx_cntl[2] & rd_half[15]}}, rd_half};
			W_BYTE: rdata = {{24{sx_cntl[2] & rd_byte[7]}}, rd_byte};
			default: rdata = rd_word;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/code_mem.sv
`timescale 1ns/10ps
`default_nettype none

module code_mem
	import cpu_pkg::*;
#(
	parameter int CODE_DEPTH = 64
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          prog_we,
	input  logic [$clog2(CODE_DEPTH)-1:0] prog_addr,
	input  logic [31:0]                   prog_data,
	input  logic                          ir_load,
	input  logic [31:0]                   pc,
	output instr_t                        instr
);

	localparam int CA_W = $clog2(CODE_DEPTH);

	logic [31:0] mem [CODE_DEPTH];

	always_ff @(posedge clk) begin
		if (prog_we)
			mem[prog_addr] <= prog_data;
	end

	// instruction register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			instr <= '0;
		else if (ir_load)
			instr <= mem[pc[CA_W+1:2]];
	end

endmodule

`default_nettype wire

// File: verilog/cpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_top
	import cpu_pkg::*;
#(
	parameter int CODE_DEPTH = 64,
	parameter int DATA_DEPTH = 64
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          run,
	input  logic                          prog_we,
	input  logic [$clog2(CODE_DEPTH)-1:0] prog_addr,
	input  logic [31:0]                   prog_data,
	output logic                          wb_en,
	output logic [4:0]                    wb_addr,
	output logic [31:0]                   wb_data,
	output logic                          retire,
	output logic                          halted
);

	seq_state_t  state;
	instr_t      instr;
	logic        ir_load;
	logic        result_load;
	logic        mem_we;
	logic        reg_we_phase;
	logic        pc_step;
	logic        pc_jump;
	logic        take;
	logic        is_mem;
	logic        sel_a_pc;
	logic        sel_b_imm;
	logic        sel_wb_mem;
	logic        sel_wb_link;
	logic        is_branch;
	logic        is_jump;
	logic        we_mem;
	logic        we_reg;
	logic [1:0]  be_mem;
	logic [1:0]  brn_type;
	logic [2:0]  sx_cntl;
	logic [3:0]  alu_cntr;
	logic        alu_s_u;
	logic        illegal;
	logic [31:0] pc;
	logic [31:0] pc_plus4;
	logic [31:0] pc_target;
	logic [31:0] br_target;
	logic [31:0] rdata_a;
	logic [31:0] rdata_b;
	logic [31:0] imm_val;
	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [31:0] alu_result;
	logic        alu_taken;
	logic [31:0] result_q;
	logic [31:0] load_data;

	assign is_mem = we_mem | sel_wb_mem;
	assign take = is_jump | (is_branch & alu_taken);

	cpu_sequencer seq0 (
		.clk(clk),
		.rst_n(rst_n),
		.run(run),
		.is_mem(is_mem),
		.illegal(illegal),
		.take(take),
		.state(state),
		.ir_load(ir_load),
		.result_load(result_load),
		.mem_we(mem_we),
		.reg_we_phase(reg_we_phase),
		.pc_step(pc_step),
		.pc_jump(pc_jump),
		.retire(retire),
		.halted(halted)
	);

	// program loading only while idle
	code_mem #(.CODE_DEPTH(CODE_DEPTH)) cmem0 (
		.clk(clk),
		.rst_n(rst_n),
		.prog_we(prog_we && state == S_IDLE),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.ir_load(ir_load),
		.pc(pc),
		.instr(instr)
	);

	cpu_cntr cntr0 (
		.instr(instr),
		.sel_a_pc(sel_a_pc),
		.sel_b_imm(sel_b_imm),
		.sel_wb_mem(sel_wb_mem),
		.sel_wb_link(sel_wb_link),
		.is_branch(is_branch),
		.is_jump(is_jump),
		.we_mem(we_mem),
		.we_reg(we_reg),
		.be_mem(be_mem),
		.brn_type(brn_type),
		.sx_cntl(sx_cntl),
		.alu_cntr(alu_cntr),
		.alu_s_u(alu_s_u),
		.illegal(illegal)
	);

	// immediates per format
	always_comb begin
		case (instr.r.opcode)
			OP_U_LUI, OP_U_AUIPC: imm_val = {{8{instr.i.imm[11]}}, instr.i.imm, 12'd0};
			OP_UJ: imm_val = {{18{instr.i.imm[11]}}, instr.i.imm, 2'b00};
			OP_S: imm_val = {{25{instr.r.hi[6]}}, instr.r.hi};
			default: imm_val = {{20{instr.i.imm[11]}}, instr.i.imm};
		endcase
	end

	assign br_target = pc + {{23{instr.r.hi[6]}}, instr.r.hi, 2'b00};
	assign pc_target = is_branch ? br_target : result_q;

	pc_counter #(.CODE_DEPTH(CODE_DEPTH)) pc0 (
		.clk(clk),
		.rst_n(rst_n),
		.step(pc_step),
		.jump(pc_jump),
		.target(pc_target),
		.pc(pc),
		.pc_plus4(pc_plus4)
	);

	reg_file rf0 (
		.clk(clk),
		.rst_n(rst_n),
		.we(wb_en),
		.waddr(wb_addr),
		.raddr_a(instr.r.rs1),
		.raddr_b(instr.r.rs2),
		.wdata(wb_data),
		.rdata_a(rdata_a),
		.rdata_b(rdata_b)
	);

	assign op_a = sel_a_pc ? pc : rdata_a;
	assign op_b = sel_b_imm ? imm_val : rdata_b;

	cpu_alu alu0 (
		.a(op_a),
		.b(op_b),
		.alu_cntr(alu_cntr),
		.alu_s_u(alu_s_u),
		.brn_type(brn_type),
		.result(alu_result),
		.taken(alu_taken)
	);

	// holds address, jump target or result until writeback
	always_ff @(posedge clk) begin
		if (result_load)
			result_q <= alu_result;
	end

	data_mem #(.DATA_DEPTH(DATA_DEPTH)) dmem0 (
		.clk(clk),
		.rst_n(rst_n),
		.we(mem_we & we_mem),
		.addr(result_q),
		.wdata(rdata_b),
		.be_mem(be_mem),
		.sx_cntl(sx_cntl),
		.rdata(load_data)
	);

	assign wb_en = reg_we_phase & we_reg;
	assign wb_addr = instr.r.rd;
	assign wb_data = sel_wb_link ? pc_plus4 : (sel_wb_mem ? load_data : result_q);

endmodule

`default_nettype wire

// File: tests/cpu_properties.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_properties
	import cpu_pkg::*;
(
	input logic       clk,
	input logic       rst_n,
	input seq_state_t state,
	input logic       is_mem,
	input logic       illegal,
	input logic       retire,
	input logic       mem_we,
	input logic       halted
);

	int fail_count = 0;

	// alu, branch and jump retire one cycle after execute
	a_retire_short: assert property (@(posedge clk) disable iff (!rst_n)
		(state == S_EXEC && !illegal && !is_mem) |=> retire)
	else begin
		fail_count++;
		$error("retire missing one cycle after execute");
	end

	// loads and stores spend one cycle in the memory phase first
	a_retire_mem: assert property (@(posedge clk) disable iff (!rst_n)
		(state == S_EXEC && !illegal && is_mem) |=> !retire ##1 retire)
	else begin
		fail_count++;
		$error("memory instruction did not retire two cycles after execute");
	end

	// next fetch right after writeback
	a_retire_fetch: assert property (@(posedge clk) disable iff (!rst_n)
		retire |=> state == S_FETCH)
	else begin
		fail_count++;
		$error("no fetch in the cycle after retire");
	end

	// memory phase only right after a load or store executes
	a_mem_we: assert property (@(posedge clk) disable iff (!rst_n)
		mem_we |-> $past(state == S_EXEC && is_mem && !illegal))
	else begin
		fail_count++;
		$error("memory write not preceded by a memory instruction in execute");
	end

	a_halt_enter: assert property (@(posedge clk) disable iff (!rst_n)
		(state == S_EXEC && illegal) |=> halted)
	else begin
		fail_count++;
		$error("illegal instruction did not halt");
	end

	a_halt_stays: assert property (@(posedge clk) disable iff (!rst_n)
		halted |=> halted)
	else begin
		fail_count++;
		$error("halted dropped without reset");
	end

endmodule

bind cpu_sequencer cpu_properties props0 (
	.clk(clk),
	.rst_n(rst_n),
	.state(state),
	.is_mem(is_mem),
	.illegal(illegal),
	.retire(retire),
	.mem_we(mem_we),
	.halted(halted)
);

`default_nettype wire

// File: tests/cpu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_tb
	import cpu_pkg::*;
();

	localparam int CODE_DEPTH = 128;

	logic        clk;
	logic        rst_n;
	logic        run;
	logic        prog_we;
	logic [6:0]  prog_addr;
	logic [31:0] prog_data;
	logic        wb_en;
	logic [4:0]  wb_addr;
	logic [31:0] wb_data;
	logic        retire;
	logic        halted;

	logic [31:0] prog [$];
	string       exp_name [$];
	int          exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] m [32];
	logic [7:0]  dmb [256];
	int          n_exec;
	int          wb_idx;
	int          n_retire;
	int          errors;
	int          timeout_cycles;
	bit          halted_seen;

	cpu_top #(.CODE_DEPTH(CODE_DEPTH), .DATA_DEPTH(64)) dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.run(run),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.wb_en(wb_en),
		.wb_addr(wb_addr),
		.wb_data(wb_data),
		.retire(retire),
		.halted(halted)
	);

	function automatic logic [31:0] encode_r(logic [6:0] hi, int rs2, int rs1, logic [2:0] f,
			int rd, logic [6:0] op);
		return {hi, 5'(rs2), 5'(rs1), f, 5'(rd), op};
	endfunction

	function automatic logic [31:0] encode_i(logic [11:0] imm, int rs1, logic [2:0] f, int rd,
			logic [6:0] op);
		return {imm, 5'(rs1), f, 5'(rd), op};
	endfunction

	function automatic logic [31:0] sext12(logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic bit branch_taken(logic [2:0] f, logic [31:0] a, logic [31:0] b);
		case (f)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd2: return $signed(a) < $signed(b);
			3'd3: return a < b;
			3'd4: return $signed(a) >= $signed(b);
			default: return a >= b;
		endcase
	endfunction

	task automatic emit(logic [31:0] w, bit runs);
		prog.push_back(w);
		if (runs)
			n_exec++;
	endtask

	// model register file follows each expected writeback
	task automatic expect_wb(string name, int rd, logic [31:0] v);
		exp_name.push_back(name);
		exp_addr.push_back(rd);
		exp_data.push_back(v);
		if (rd != 0)
			m[rd] = v;
	endtask

	task automatic reg_op(string name, bit alt, logic [2:0] f, int rd, int rs1, int rs2);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] v;
		a = m[rs1];
		b = m[rs2];
		case ({alt, f})
			4'b0000: v = a + b;
			4'b0001: v = {31'd0, $signed(a) < $signed(b)};
			4'b0010: v = {31'd0, a < b};
			4'b0011: v = a & b;
			4'b0100: v = a | b;
			4'b0101: v = a ^ b;
			4'b0110: v = a << b[4:0];
			4'b0111: v = a >> b[4:0];
			4'b1000: v = a - b;
			4'b1001: v = $signed(a) >>> b[4:0];
			default: v = b;
		endcase
		emit(encode_r(alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f, rd, OP_R), 1'b1);
		expect_wb(name, rd, v);
	endtask

	task automatic imm_op(string name, logic [2:0] f, int rd, int rs1, logic [11:0] imm);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] v;
		a = m[rs1];
		b = sext12(imm);
		case (f)
			3'd0: v = a + b;
			3'd1: v = {31'd0, $signed(a) < $signed(b)};
			3'd2: v = a & b;
			3'd3: v = a | b;
			3'd4: v = a ^ b;
			3'd5: v = a << b[4:0];
			3'd6: v = a >> b[4:0];
			default: v = $signed(a) >>> b[4:0];
		endcase
		emit(encode_i(imm, rs1, f, rd, OP_R_I), 1'b1);
		expect_wb(name, rd, v);
	endtask

	// upper part by lui, low twelve bits added after
	task automatic load_const(int rd, logic [31:0] val);
		logic [31:0] t;
		logic [11:0] up;
		t = val + 32'h800;
		up = t[23:12];
		emit(encode_i(up, 0, 3'd0, rd, OP_U_LUI), 1'b1);
		expect_wb("lui_seed", rd, {{8{up[11]}}, up, 12'd0});
		imm_op("addi_seed", 3'd0, rd, rd, val[11:0]);
	endtask

	task automatic store_op(logic [2:0] f, int rs2, int rs1, logic [6:0] off);
		logic [31:0] ad;
		logic [31:0] d;
		ad = m[rs1] + {{25{off[6]}}, off};
		d = m[rs2];
		case (f)
			3'd1: begin
				for (int k = 0; k < 4; k++)
					dmb[{ad[7:2], 2'b00} + k] = d[8*k +: 8];
			end
			3'd2: begin
				for (int k = 0; k < 2; k++)
					dmb[{ad[7:1], 1'b0} + k] = d[8*k +: 8];
			end
			default: dmb[ad[7:0]] = d[7:0];
		endcase
		emit(encode_r(off, rs2, rs1, f, 0, OP_S), 1'b1);
	endtask

	task automatic load_op(string name, logic [2:0] f, int rd, int rs1, logic [11:0] off);
		logic [31:0] ad;
		logic [7:0]  wa;
		logic [15:0] h;
		logic [7:0]  b8;
		logic [31:0] v;
		ad = m[rs1] + sext12(off);
		wa = {ad[7:2], 2'b00};
		h = {dmb[{ad[7:1], 1'b1}], dmb[{ad[7:1], 1'b0}]};
		b8 = dmb[ad[7:0]];
		case (f)
			3'd1: v = {dmb[wa + 3], dmb[wa + 2], dmb[wa + 1], dmb[wa]};
			3'd2: v = {{16{h[15]}}, h};
			3'd3: v = {16'd0, h};
			3'd4: v = {{24{b8[7]}}, b8};
			default: v = {24'd0, b8};
		endcase
		emit(encode_i(off, rs1, f, rd, OP_I), 1'b1);
		expect_wb(name, rd, v);
	endtask

	// branch over one marker write
	task automatic branch_op(string name, logic [2:0] f, int rs1, int rs2);
		bit t;
		t = branch_taken(f, m[rs1], m[rs2]);
		emit(encode_r(7'd2, rs2, rs1, f, 0, OP_SB), 1'b1);
		emit(encode_i(12'd77, 0, 3'd0, 20, OP_R_I), !t);
		if (!t)
			expect_wb(name, 20, 32'd77);
	endtask

	task automatic build_program();
		logic [31:0] r;
		int          pc;
		int          tgt;
		for (int n = 1; n <= 4; n++) begin
			r = $urandom;
			load_const(n, {{9{r[22]}}, r[22:0]});
		end
		load_const(5, 32'hFFFFFF9C);
		load_const(6, 32'd3);
		reg_op("add", 1'b0, 3'd0, 7, 1, 2);
		reg_op("slt", 1'b0, 3'd1, 7, 5, 6);
		reg_op("sltu", 1'b0, 3'd2, 7, 5, 6);
		reg_op("and", 1'b0, 3'd3, 7, 1, 2);
		reg_op("or", 1'b0, 3'd4, 7, 1, 2);
		reg_op("xor", 1'b0, 3'd5, 7, 3, 4);
		reg_op("sll", 1'b0, 3'd6, 7, 1, 6);
		reg_op("srl", 1'b0, 3'd7, 7, 5, 6);
		reg_op("sub", 1'b1, 3'd0, 7, 1, 2);
		reg_op("sra", 1'b1, 3'd1, 7, 5, 6);
		reg_op("pass_b", 1'b1, 3'd2, 7, 1, 3);
		imm_op("addi", 3'd0, 8, 1, 12'hF85);
		imm_op("slti", 3'd1, 8, 5, 12'd1);
		imm_op("andi", 3'd2, 8, 3, 12'h0F0);
		imm_op("ori", 3'd3, 8, 4, 12'h801);
		imm_op("xori", 3'd4, 8, 2, 12'hFFF);
		imm_op("slli", 3'd5, 8, 1, 12'd7);
		imm_op("srli", 3'd6, 8, 5, 12'd4);
		imm_op("srai", 3'd7, 8, 5, 12'd4);
		imm_op("x0_write", 3'd0, 0, 0, 12'd5);
		emit(encode_i(12'hABC, 0, 3'd0, 9, OP_U_LUI), 1'b1);
		expect_wb("lui", 9, 32'hFFABC000);
		pc = prog.size() * 4;
		emit(encode_i(12'h001, 0, 3'd0, 9, OP_U_AUIPC), 1'b1);
		expect_wb("auipc", 9, 32'(pc) + 32'h1000);
		imm_op("mem_base", 3'd0, 10, 0, 12'd16);
		store_op(3'd1, 1, 10, 7'd0);
		load_op("lw", 3'd1, 11, 10, 12'd0);
		store_op(3'd2, 5, 10, 7'd6);
		load_op("lh", 3'd2, 12, 10, 12'd6);
		load_op("lhu", 3'd3, 13, 10, 12'd6);
		store_op(3'd3, 5, 10, 7'd9);
		load_op("lb", 3'd4, 14, 10, 12'd9);
		load_op("lbu", 3'd5, 15, 10, 12'd9);
		store_op(3'd3, 6, 10, 7'd1);
		load_op("lw_merge", 3'd1, 16, 10, 12'd0);
		branch_op("beq_t", 3'd0, 6, 6);
		branch_op("beq_n", 3'd0, 5, 6);
		branch_op("bne_t", 3'd1, 5, 6);
		branch_op("bne_n", 3'd1, 6, 6);
		branch_op("blt_t", 3'd2, 5, 6);
		branch_op("blt_n", 3'd2, 6, 5);
		branch_op("bltu_n", 3'd3, 5, 6);
		branch_op("bltu_t", 3'd3, 6, 5);
		branch_op("bge_n", 3'd4, 5, 6);
		branch_op("bge_t", 3'd4, 6, 6);
		branch_op("bgeu_t", 3'd5, 5, 6);
		branch_op("bgeu_n", 3'd5, 6, 5);
		pc = prog.size() * 4;
		emit(encode_i(12'd2, 0, 3'd0, 22, OP_UJ), 1'b1);
		expect_wb("jal_link", 22, 32'(pc + 4));
		emit(encode_i(12'd55, 0, 3'd0, 25, OP_R_I), 1'b0);
		tgt = (prog.size() + 3) * 4;
		imm_op("jalr_base", 3'd0, 23, 0, 12'(tgt));
		pc = prog.size() * 4;
		emit(encode_i(12'd0, 23, 3'd0, 24, OP_I), 1'b1);
		expect_wb("jalr_link", 24, 32'(pc + 4));
		emit(encode_i(12'd56, 0, 3'd0, 25, OP_R_I), 1'b0);
		imm_op("after_jump", 3'd0, 26, 0, 12'd9);
		// unknown opcode, then a write that must never happen
		emit(32'hFFFFFFFF, 1'b0);
		emit(encode_i(12'd1, 0, 3'd0, 27, OP_R_I), 1'b0);
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// trace and halt checks, sampled mid-cycle
	always @(negedge clk) begin
		if (rst_n && wb_en) begin
			assert (wb_idx < exp_data.size())
			else begin
				errors++;
				$display("unexpected writeback to x%0d after the last expected one", wb_addr);
			end
			if (wb_idx < exp_data.size()) begin
				assert (wb_addr == 5'(exp_addr[wb_idx]) && wb_data === exp_data[wb_idx])
				else begin
					errors++;
					$display("CHECK FAILED %s: expected x%0d=%h, actual x%0d=%h",
						exp_name[wb_idx], exp_addr[wb_idx], exp_data[wb_idx],
						wb_addr, wb_data);
				end
				wb_idx++;
			end
		end
		if (rst_n && retire)
			n_retire++;
		if (halted_seen) begin
			assert (halted && !wb_en && !retire)
			else begin
				errors++;
				$display("core left halt or kept writing after an illegal instruction");
			end
		end
		if (rst_n && halted)
			halted_seen = 1'b1;
	end

	initial begin
		wait (run === 1'b1);
		repeat (timeout_cycles) @(posedge clk);
		$display("timeout: core did not halt within %0d cycles", timeout_cycles);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		int cycles;
		int prop_errors;
		rst_n = 1'b0;
		run = 1'b0;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		n_exec = 0;
		wb_idx = 0;
		n_retire = 0;
		errors = 0;
		halted_seen = 1'b0;
		for (int n = 0; n < 32; n++)
			m[n] = '0;
		void'($urandom(28));
		build_program();
		timeout_cycles = prog.size() * 5 + 100;
		repeat (2) @(posedge clk);
		#1 rst_n = 1'b1;
		foreach (prog[i]) begin
			@(posedge clk);
			#1;
			prog_we = 1'b1;
			prog_addr = 7'(i);
			prog_data = prog[i];
		end
		@(posedge clk);
		#1 prog_we = 1'b0;
		repeat (3) begin
			@(negedge clk);
			assert (!wb_en && !retire && !halted)
			else begin
				errors++;
				$display("core active before run");
			end
		end
		@(posedge clk);
		#1 run = 1'b1;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!retire && cycles < 8);
		assert (cycles <= 4)
		else begin
			errors++;
			$display("CHECK FAILED first_retire: expected <= 4 cycles, actual %0d", cycles);
		end
		wait (halted_seen);
		repeat (20) @(negedge clk);
		assert (wb_idx == exp_data.size())
		else begin
			errors++;
			$display("CHECK FAILED wb_count: expected %0d, actual %0d", exp_data.size(), wb_idx);
		end
		assert (n_retire == n_exec)
		else begin
			errors++;
			$display("CHECK FAILED retire_count: expected %0d, actual %0d", n_exec, n_retire);
		end
		prop_errors = dut0.seq0.props0.fail_count;
		$display("errors: %0d trace, %0d property", errors, prop_errors);
		if (errors == 0 && prop_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: cpu.f
verilog/cpu_pkg.sv
verilog/cpu_cntr.sv
verilog/cpu_sequencer.sv
verilog/pc_counter.sv
verilog/reg_file.sv
verilog/cpu_alu.sv
verilog/data_mem.sv
verilog/code_mem.sv
verilog/cpu_top.sv
tests/cpu_properties.sv
tests/cpu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb \
	-f cpu.f -o cpu_sim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/cpu_sim +verilator+error+limit+1000 > sim.log 2>&1

grep -q '^\*\*\* PASSED \*\*\*$' sim.log \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed, see sim.log"; exit 1; }
